//--- design/cache_pkg.sv
package cache_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------

    // Width of one data word, which is also the size of one cache line
    localparam int WORD_WIDTH = 32;

    // APB byte address width
    // Bit 15 picks the probe region and bits 1:0 are the byte offset
    localparam int APB_ADDR_WIDTH = 16;

    // Backing memory word address, taken from APB address bits 14:2
    localparam int WORD_ADDR_WIDTH = 13;

    // ----------------------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------------------

    typedef logic [WORD_WIDTH-1:0]      word_t;
    typedef logic [APB_ADDR_WIDTH-1:0]  apb_addr_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;

    // ----------------------------------------------------------------------
    // Bus structs
    // ----------------------------------------------------------------------

    // Everything the APB master drives towards the cache
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        word_t     pwdata;
    } apb_req_t;

    // Request to the backing memory
    // The controller keeps it constant until the memory returns ready
    typedef struct packed {
        logic       valid;
        logic       write;
        word_addr_t addr;
        word_t      wdata;
    } mem_req_t;

endpackage

//--- design/status_memory.sv
`timescale 1ns/1ps

module status_memory #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    // Read/write port used by lookups and line updates
    input  logic [INDEX_WIDTH-1:0] rw_index_i,
    input  logic                   write_i,
    input  logic                   valid_i,
    input  logic                   dirty_i,
    input  logic                   read_rw_i,
    // Read-only port used by status probes
    input  logic [INDEX_WIDTH-1:0] read_index_i,
    input  logic                   read_probe_i,
    // Bit 0 comes from the read/write port and bit 1 from the probe port
    output logic [1:0]             valid_o,
    output logic [1:0]             dirty_o
);

    localparam int DEPTH = 2 ** INDEX_WIDTH;

    // One valid and one dirty bit per line
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] dirty_q;

    // Registered read results of the two ports
    logic rw_valid_q;
    logic rw_dirty_q;
    logic probe_valid_q;
    logic probe_dirty_q;

    // ----------------------------------------------------------------------
    // Status arrays
    // ----------------------------------------------------------------------

    // Reset invalidates every line, so the cache starts empty and clean
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (write_i) begin
            // Both bits always change together on a line update
            valid_q[rw_index_i] <= valid_i;
            dirty_q[rw_index_i] <= dirty_i;
        end
    end

    // Port 0 only reads when no write is pending on the same port
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rw_valid_q <= 1'b0;
            rw_dirty_q <= 1'b0;
        end else if (!write_i && read_rw_i) begin
            rw_valid_q <= valid_q[rw_index_i];
            rw_dirty_q <= dirty_q[rw_index_i];
        end
    end

    // Port 1 never writes, so a probe cannot disturb the lookup path
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            probe_valid_q <= 1'b0;
            probe_dirty_q <= 1'b0;
        end else if (read_probe_i) begin
            probe_valid_q <= valid_q[read_index_i];
            probe_dirty_q <= dirty_q[read_index_i];
        end
    end

    assign valid_o = {probe_valid_q, rw_valid_q};
    assign dirty_o = {probe_dirty_q, rw_dirty_q};

    // The controller only marks lines dirty while also making them valid
    // So neither port should ever report a dirty line that is not valid
    a_dirty_implies_valid: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (dirty_o & ~valid_o) == 2'b00
    );

endmodule

//--- design/tag_memory.sv
`timescale 1ns/1ps

module tag_memory #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                                              clk_i,
    input  logic [INDEX_WIDTH-1:0]                            index_i,
    input  logic                                              write_i,
    input  logic                                              read_i,
    input  logic [cache_pkg::WORD_ADDR_WIDTH-INDEX_WIDTH-1:0] tag_i,
    output logic [cache_pkg::WORD_ADDR_WIDTH-INDEX_WIDTH-1:0] tag_o
);

    import cache_pkg::*;

    // The tag is whatever part of the word address the index does not cover
    localparam int TAG_WIDTH = WORD_ADDR_WIDTH - INDEX_WIDTH;
    localparam int DEPTH     = 2 ** INDEX_WIDTH;

    // ----------------------------------------------------------------------
    // Tag array
    // ----------------------------------------------------------------------

    // An entry only means something while the matching valid bit is set
    logic [TAG_WIDTH-1:0] tags_q [DEPTH];

    // Single port with the write taking priority over the read
    // The output keeps its last value while no read is requested
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            tags_q[index_i] <= tag_i;
        end else if (read_i) begin
            tag_o <= tags_q[index_i];
        end
    end

endmodule

//--- design/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                   clk_i,
    input  logic [INDEX_WIDTH-1:0] index_i,
    input  logic                   write_i,
    input  logic                   read_i,
    input  cache_pkg::word_t       wdata_i,
    output cache_pkg::word_t       rdata_o
);

    import cache_pkg::*;

    localparam int DEPTH = 2 ** INDEX_WIDTH;

    // ----------------------------------------------------------------------
    // Word array
    // ----------------------------------------------------------------------

    // One word per line since lines are a single word wide
    word_t words_q [DEPTH];

    // Write wins over read, as on the other arrays
    // Holding rdata_o between reads lets the controller use the victim word
    // for the whole write-back without reading the array again
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            words_q[index_i] <= wdata_i;
        end else if (read_i) begin
            rdata_o <= words_q[index_i];
        end
    end

endmodule

//--- design/cache_controller.sv
`timescale 1ns/1ps

module cache_controller #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    // APB slave side
    input  cache_pkg::apb_req_t    apb_i,
    output cache_pkg::word_t       prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    // Backing memory side
    output cache_pkg::mem_req_t    mem_req_o,
    input  logic                   mem_ready_i,
    input  cache_pkg::word_t       mem_rdata_i,
    // Controls shared by the status, tag and data arrays
    output logic [INDEX_WIDTH-1:0] index_o,
    output logic                   read_o,
    output logic                   write_o,
    output logic [cache_pkg::WORD_ADDR_WIDTH-INDEX_WIDTH-1:0] tag_o,
    output logic                   valid_o,
    output logic                   dirty_o,
    output cache_pkg::word_t       wdata_o,
    output logic [INDEX_WIDTH-1:0] probe_index_o,
    output logic                   probe_read_o,
    // Array read results, bit 0 of the status is the lookup port
    input  logic [cache_pkg::WORD_ADDR_WIDTH-INDEX_WIDTH-1:0] tag_i,
    input  logic [1:0]             valid_i,
    input  logic [1:0]             dirty_i,
    input  cache_pkg::word_t       rdata_i
);

    import cache_pkg::*;

    localparam int TAG_WIDTH = WORD_ADDR_WIDTH - INDEX_WIDTH;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL,
        RESPOND
    } state_t;

    state_t               state_q;
    state_t               state_d;
    word_t                fill_q;
    word_addr_t           req_addr;
    logic [TAG_WIDTH-1:0] req_tag;
    logic                 setup;
    logic                 probe_region;
    logic                 misaligned;
    logic                 hit;
    logic                 victim_dirty;

    // ----------------------------------------------------------------------
    // Request decode
    // ----------------------------------------------------------------------

    // Word address of the transfer with the byte offset dropped
    assign req_addr     = apb_i.paddr[WORD_ADDR_WIDTH+1:2];
    assign req_tag      = req_addr[WORD_ADDR_WIDTH-1:INDEX_WIDTH];
    assign setup        = apb_i.psel && !apb_i.penable;
    assign probe_region = apb_i.paddr[APB_ADDR_WIDTH-1];
    assign misaligned   = (apb_i.paddr[1:0] != 2'b00);

    // Lookup results are only meaningful in LOOKUP, one cycle after setup
    assign hit          = valid_i[0] && (tag_i == req_tag);
    assign victim_dirty = valid_i[0] && dirty_i[0];

    // ----------------------------------------------------------------------
    // Array controls
    // ----------------------------------------------------------------------

    // The master holds paddr for the whole transfer, so the index can come
    // straight from the bus in every state
    assign index_o       = req_addr[INDEX_WIDTH-1:0];
    assign probe_index_o = apb_i.paddr[INDEX_WIDTH+1:2];
    assign tag_o         = req_tag;

    // Arrays are only read in the setup cycle, after that their outputs
    // hold the victim line until the transfer ends
    assign read_o       = (state_q == IDLE) && setup && !probe_region;
    assign probe_read_o = (state_q == IDLE) && setup && probe_region;

    // Every line update leaves a valid line behind
    assign valid_o = 1'b1;

    // Processor writes make the line dirty, a fill leaves it clean
    assign dirty_o = (state_q != FILL);
    assign wdata_o = (state_q == FILL) ? mem_rdata_i : apb_i.pwdata;

    // ----------------------------------------------------------------------
    // Miss FSM
    // ----------------------------------------------------------------------

    always_comb begin
        state_d   = state_q;
        pready_o  = 1'b0;
        pslverr_o = 1'b0;
        prdata_o  = '0;
        write_o   = 1'b0;
        mem_req_o = '0;
        case (state_q)
            IDLE: begin
                if (setup) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (misaligned) begin
                    // Rejected without touching any array
                    pready_o  = 1'b1;
                    pslverr_o = 1'b1;
                    state_d   = IDLE;
                end else if (probe_region) begin
                    // Probe writes are accepted and dropped
                    pready_o = 1'b1;
                    prdata_o = {{(WORD_WIDTH-2){1'b0}}, dirty_i[1], valid_i[1]};
                    state_d  = IDLE;
                end else if (hit || (apb_i.pwrite && !victim_dirty)) begin
                    // Hits and clean write misses finish right away
                    pready_o = 1'b1;
                    prdata_o = rdata_i;
                    write_o  = apb_i.pwrite;
                    state_d  = IDLE;
                end else if (victim_dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = FILL;
                end
            end
            WRITEBACK: begin
                // Victim address is rebuilt from its stored tag and the index
                mem_req_o.valid = 1'b1;
                mem_req_o.write = 1'b1;
                mem_req_o.addr  = {tag_i, index_o};
                mem_req_o.wdata = rdata_i;
                if (mem_ready_i) begin
                    if (apb_i.pwrite) begin
                        write_o = 1'b1;
                        state_d = RESPOND;
                    end else begin
                        state_d = FILL;
                    end
                end
            end
            FILL: begin
                mem_req_o.valid = 1'b1;
                mem_req_o.addr  = req_addr;
                if (mem_ready_i) begin
                    write_o = 1'b1;
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                pready_o = 1'b1;
                prdata_o = fill_q;
                state_d  = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Fetched word, returned to the master in RESPOND
    always_ff @(posedge clk_i) begin
        if (state_q == FILL && mem_ready_i) begin
            fill_q <= mem_rdata_i;
        end
    end

    // ----------------------------------------------------------------------
    // Protocol checks
    // ----------------------------------------------------------------------

    // The request depends on the held APB address and on the held array
    // outputs, so it must not move until the memory accepts it
    a_mem_req_stable: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        mem_req_o.valid && !mem_ready_i |=> $stable(mem_req_o)
    );

    // Completion is only signalled while the master is in an access phase
    a_pready_in_access: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        pready_o |-> apb_i.psel && apb_i.penable
    );

endmodule

//--- design/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    // APB slave port towards the processor
    input  cache_pkg::apb_req_t apb_i,
    output cache_pkg::word_t    prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    // Backing memory port
    output cache_pkg::mem_req_t mem_req_o,
    input  logic                mem_ready_i,
    input  cache_pkg::word_t    mem_rdata_i
);

    import cache_pkg::*;

    localparam int TAG_WIDTH = WORD_ADDR_WIDTH - INDEX_WIDTH;

    // ----------------------------------------------------------------------
    // Array control and result wires
    // ----------------------------------------------------------------------

    logic [INDEX_WIDTH-1:0] index;
    logic                   read;
    logic                   write;
    logic [TAG_WIDTH-1:0]   tag_wr;
    logic [TAG_WIDTH-1:0]   tag_rd;
    logic                   valid_wr;
    logic                   dirty_wr;
    logic [1:0]             valid_rd;
    logic [1:0]             dirty_rd;
    word_t                  wdata;
    word_t                  rdata;
    logic [INDEX_WIDTH-1:0] probe_index;
    logic                   probe_read;

    cache_controller #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_controller (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .apb_i         (apb_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .mem_req_o     (mem_req_o),
        .mem_ready_i   (mem_ready_i),
        .mem_rdata_i   (mem_rdata_i),
        .index_o       (index),
        .read_o        (read),
        .write_o       (write),
        .tag_o         (tag_wr),
        .valid_o       (valid_wr),
        .dirty_o       (dirty_wr),
        .wdata_o       (wdata),
        .probe_index_o (probe_index),
        .probe_read_o  (probe_read),
        .tag_i         (tag_rd),
        .valid_i       (valid_rd),
        .dirty_i       (dirty_rd),
        .rdata_i       (rdata)
    );

    // All three arrays share one index, read enable and write enable
    status_memory #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_status (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .rw_index_i   (index),
        .write_i      (write),
        .valid_i      (valid_wr),
        .dirty_i      (dirty_wr),
        .read_rw_i    (read),
        .read_index_i (probe_index),
        .read_probe_i (probe_read),
        .valid_o      (valid_rd),
        .dirty_o      (dirty_rd)
    );

    tag_memory #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_tag (
        .clk_i   (clk_i),
        .index_i (index),
        .write_i (write),
        .read_i  (read),
        .tag_i   (tag_wr),
        .tag_o   (tag_rd)
    );

    data_memory #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_data (
        .clk_i   (clk_i),
        .index_i (index),
        .write_i (write),
        .read_i  (read),
        .wdata_i (wdata),
        .rdata_o (rdata)
    );

endmodule

//--- include/cache_tb_tasks.svh
// ----------------------------------------------------------------------
// APB master
// ----------------------------------------------------------------------

// One transfer with a single setup cycle, then an access phase held until pready
// Outputs are sampled at the falling edge where the DUT has settled
task automatic apb_transfer(input logic write, input apb_addr_t addr, input word_t wdata,
                            output word_t rdata, output logic slverr);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
        @(negedge clk);
    end
    rdata  = prdata;
    slverr = pslverr;
    // The bus goes idle on the edge that completes the transfer
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
endtask

task automatic apb_write(input apb_addr_t addr, input word_t wdata, output logic slverr);
    word_t ignored;
    apb_transfer(1'b1, addr, wdata, ignored, slverr);
endtask

task automatic apb_read(input apb_addr_t addr, output word_t rdata, output logic slverr);
    apb_transfer(1'b0, addr, '0, rdata, slverr);
endtask

// ----------------------------------------------------------------------
// Checks
// ----------------------------------------------------------------------

task automatic check_value(input string name, input word_t got, input word_t expected);
    assert (got === expected) else begin
        $display("FAILED %s: got %h, expected %h", name, got, expected);
        error_count++;
    end
endtask

task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
        $display("Error at %0t ns: %s", $time, what);
        error_count++;
    end
endtask

//--- test/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    import cache_pkg::*;

    localparam int INDEX_WIDTH = 6;
    localparam int TAG_WIDTH   = WORD_ADDR_WIDTH - INDEX_WIDTH;
    localparam int NUM_LINES   = 2 ** INDEX_WIDTH;
    localparam int MEM_WORDS   = 2 ** WORD_ADDR_WIDTH;
    localparam int NUM_OPS     = 400;
    // Only a few tags per index, so lines conflict and get evicted often
    localparam int TAG_RANGE   = 4;
    // Each operation fits in 20 cycles, and so do the probe sweeps at both ends
    localparam int TIMEOUT_CYCLES = (NUM_OPS + 2 * NUM_LINES) * 20;

    logic     clk;
    logic     arst_n;
    apb_req_t apb_req;
    word_t    prdata;
    logic     pready;
    logic     pslverr;
    mem_req_t mem_req;
    logic     mem_ready;
    word_t    mem_rdata;

    integer   seed;
    int       error_count;

    // Reference model of the cache lines and of the backing memory
    logic                 model_valid [NUM_LINES];
    logic                 model_dirty [NUM_LINES];
    logic [TAG_WIDTH-1:0] model_tag   [NUM_LINES];
    word_t                model_word  [NUM_LINES];
    word_t                model_mem   [MEM_WORDS];
    mem_req_t             expected_reqs [$];

    // Responder side, which only sees the memory port
    word_t                backing_mem [MEM_WORDS];
    mem_req_t             req_log [$];
    logic                 mem_req_seen;

    `include "cache_tb_tasks.svh"

    cache_top #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) DUT (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .apb_i       (apb_req),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .mem_req_o   (mem_req),
        .mem_ready_i (mem_ready),
        .mem_rdata_i (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Backing memory responder
    // ----------------------------------------------------------------------

    // A request is seen at the falling edge and answered after 0 to 3 cycles
    // Ready stays high for exactly one cycle
    initial begin : responder
        mem_req_t req;
        int       delay;
        mem_ready <= 1'b0;
        mem_rdata <= '0;
        forever begin
            @(negedge clk);
            if (arst_n && mem_req.valid) begin
                mem_req_seen = 1'b1;
                req   = mem_req;
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge clk);
                @(posedge clk);
                mem_ready <= 1'b1;
                mem_rdata <= backing_mem[req.addr];
                if (req.write) begin
                    backing_mem[req.addr] = req.wdata;
                end
                req_log.push_back(req);
                @(posedge clk);
                mem_ready <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------

    // Updates the model line for one aligned data access, queues the memory
    // requests it needs and returns the word a read must see
    task automatic predict_access(input logic write, input logic [INDEX_WIDTH-1:0] index,
                                  input logic [TAG_WIDTH-1:0] tag, input word_t wdata,
                                  output word_t rdata);
        mem_req_t req;
        expected_reqs.delete();
        if (!(model_valid[index] && model_tag[index] == tag)) begin
            // A dirty victim goes back to memory before anything else
            if (model_valid[index] && model_dirty[index]) begin
                req       = '0;
                req.valid = 1'b1;
                req.write = 1'b1;
                req.addr  = {model_tag[index], index};
                req.wdata = model_word[index];
                expected_reqs.push_back(req);
                model_mem[req.addr] = req.wdata;
            end
            // Lines are one word wide, so only a read miss fetches
            if (!write) begin
                req       = '0;
                req.valid = 1'b1;
                req.addr  = {tag, index};
                expected_reqs.push_back(req);
                model_word[index]  = model_mem[req.addr];
                model_dirty[index] = 1'b0;
            end
            model_valid[index] = 1'b1;
            model_tag[index]   = tag;
        end
        if (write) begin
            model_word[index]  = wdata;
            model_dirty[index] = 1'b1;
        end
        rdata = model_word[index];
    endtask

    task automatic check_requests();
        int count;
        check_true(req_log.size() == expected_reqs.size(),
                   "number of memory requests differs from the model");
        count = (req_log.size() < expected_reqs.size()) ? req_log.size() : expected_reqs.size();
        for (int i = 0; i < count; i++) begin
            check_value("mem_req_o.write", req_log[i].write, expected_reqs[i].write);
            check_value("mem_req_o.addr", req_log[i].addr, expected_reqs[i].addr);
            if (expected_reqs[i].write) begin
                check_value("mem_req_o.wdata", req_log[i].wdata, expected_reqs[i].wdata);
            end
        end
        if (expected_reqs.size() == 0) begin
            check_true(!mem_req_seen, "memory request during an access that needs none");
        end
    endtask

    // ----------------------------------------------------------------------
    // Test operations
    // ----------------------------------------------------------------------

    task automatic data_access(input logic write, input logic [INDEX_WIDTH-1:0] index,
                               input logic [TAG_WIDTH-1:0] tag, input word_t wdata);
        word_t expected;
        word_t got;
        logic  slverr;
        predict_access(write, index, tag, wdata, expected);
        req_log.delete();
        mem_req_seen = 1'b0;
        apb_transfer(write, {1'b0, tag, index, 2'b00}, wdata, got, slverr);
        check_value("pslverr_o", slverr, 1'b0);
        if (!write) begin
            check_value("prdata_o", got, expected);
        end
        check_requests();
    endtask

    // Probe addresses carry random upper bits, which the DUT must ignore
    task automatic probe_line(input logic [INDEX_WIDTH-1:0] index);
        logic [TAG_WIDTH-1:0] upper;
        word_t                got;
        logic                 slverr;
        upper = $random(seed);
        apb_read({1'b1, upper, index, 2'b00}, got, slverr);
        check_value("pslverr_o", slverr, 1'b0);
        check_value("prdata_o", got,
                    {{(WORD_WIDTH-2){1'b0}}, model_dirty[index], model_valid[index]});
    endtask

    // A misaligned access must fail and leave the line as it was
    task automatic misaligned_access(input logic write, input logic [INDEX_WIDTH-1:0] index,
                                     input logic [TAG_WIDTH-1:0] tag, input word_t wdata);
        logic [1:0] offset;
        word_t      got;
        logic       slverr;
        offset = ($unsigned($random(seed)) % 3) + 1;
        mem_req_seen = 1'b0;
        apb_transfer(write, {1'b0, tag, index, offset}, wdata, got, slverr);
        check_value("pslverr_o", slverr, 1'b1);
        check_true(!mem_req_seen, "memory request from a misaligned access");
        probe_line(index);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin : main
        logic                   write;
        logic [INDEX_WIDTH-1:0] index;
        logic [TAG_WIDTH-1:0]   tag;
        word_t                  wdata;
        logic                   slverr;
        int                     kind;
        seed        = 32'hfcf9cef3;
        error_count = 0;
        arst_n  <= 1'b0;
        apb_req <= '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            backing_mem[i] = $random(seed);
            model_mem[i]   = backing_mem[i];
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_dirty[i] = 1'b0;
            model_tag[i]   = '0;
            model_word[i]  = '0;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // Right after reset the cache is empty and both ports are quiet
        @(negedge clk);
        check_value("pready_o", pready, 1'b0);
        check_value("mem_req_o.valid", mem_req.valid, 1'b0);
        for (int i = 0; i < NUM_LINES; i++) begin
            probe_line(i);
        end

        for (int op = 0; op < NUM_OPS; op++) begin
            kind  = $unsigned($random(seed)) % 8;
            write = $random(seed);
            index = $random(seed);
            tag   = $unsigned($random(seed)) % TAG_RANGE;
            wdata = $random(seed);
            if (kind < 6) begin
                data_access(kind >= 3, index, tag, wdata);
            end else if (kind == 6) begin
                // Writes to the probe region are dropped by the DUT
                if (write) begin
                    apb_write({1'b1, tag, index, 2'b00}, wdata, slverr);
                    check_value("pslverr_o", slverr, 1'b0);
                end
                probe_line(index);
            end else begin
                misaligned_access(write, index, tag, wdata);
            end
        end

        for (int i = 0; i < NUM_LINES; i++) begin
            probe_line(i);
        end

        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the test did not finish", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
design/cache_pkg.sv
design/status_memory.sv
design/tag_memory.sv
design/data_memory.sv
design/cache_controller.sv
design/cache_top.sv
test/cache_tb.sv
